// File: include/simpleRisc_cfg.svh
`ifndef SIMPLE_RISC_CFG_SVH
`define SIMPLE_RISC_CFG_SVH

// core sizes
`define SR_WORD_WIDTH 16
`define SR_REG_COUNT 8
`define SR_REG_SEL_WIDTH 3
`define SR_IMM_WIDTH 8           // imm8 field, sign-extended to a word

`endif

// File: hw/simpleRiscPkg.sv
`include "simpleRisc_cfg.svh"

package simpleRiscPkg;

    localparam logic [2:0] opcodeMov = 3'b110;
    localparam logic [2:0] opcodeAlu = 3'b101;

    localparam logic [1:0] opMovReg = 2'b00;
    localparam logic [1:0] opMovImm = 2'b01;
    localparam logic [1:0] opCmp    = 2'b01;  // within the ALU class
    localparam logic [1:0] opMvn    = 2'b11;

    // one-hot register select
    localparam logic [2:0] nselRn = 3'b001;
    localparam logic [2:0] nselRd = 3'b010;
    localparam logic [2:0] nselRm = 3'b100;

    localparam logic vselC   = 1'b0;
    localparam logic vselImm = 1'b1;

    typedef enum logic [1:0] {
        aluAdd,
        aluSub,                               // CMP
        aluAnd,
        aluNot                                // MVN
    } aluOp_t;

    typedef enum logic [1:0] {
        shiftNone,
        shiftLeft,
        shiftRightLogic,
        shiftRightArith
    } shiftOp_t;

    typedef enum logic [2:0] {
        stWait,
        stWriteRn,
        stReadRm,
        stReadRn,
        stShift,
        stExecute,
        stWriteRd
    } ctrlState_t;

    typedef struct packed {
        logic [2:0]                    opcode;
        logic [1:0]                    op;
        logic [`SR_REG_SEL_WIDTH-1:0]  rn;
        logic [`SR_REG_SEL_WIDTH-1:0]  rd;
        logic [`SR_REG_SEL_WIDTH-1:0]  rm;
        shiftOp_t                      shift;
        aluOp_t                        aluOp;
        logic [`SR_WORD_WIDTH-1:0]     imm;
    } decodedInstr_t;

    typedef struct packed {
        logic [2:0] nsel;
        logic       vsel;
        logic       write;
        logic       loada;
        logic       loadb;
        logic       loadc;
        logic       loads;
        logic       asel;                     // A operand forced to zero
        logic       bsel;                     // B operand from immediate
    } controlWord_t;

    typedef struct packed {
        logic z;
        logic n;
        logic v;
    } statusFlags_t;

endpackage

// File: hw/instructionDecoder.sv
`include "simpleRisc_cfg.svh"

module instructionDecoder (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           load,
    input  logic [`SR_WORD_WIDTH-1:0]      in,
    output simpleRiscPkg::decodedInstr_t   instr
);
    import simpleRiscPkg::*;

    logic [`SR_WORD_WIDTH-1:0] ir;

    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= '0;
        end else if (load) begin
            ir <= in;
        end
    end

    // field layout: opcode op rn rd shift rm, imm8 overlaps rd/shift/rm
    always_comb begin
        instr.opcode = ir[15:13];
        instr.op     = ir[12:11];
        instr.rn     = ir[10:8];
        instr.rd     = ir[7:5];
        instr.rm     = ir[2:0];
        instr.shift  = shiftOp_t'(ir[4:3]);
        instr.aluOp  = aluOp_t'(ir[12:11]);   // op maps straight onto the ALU op
        instr.imm    = {{(`SR_WORD_WIDTH - `SR_IMM_WIDTH){ir[`SR_IMM_WIDTH-1]}},
                        ir[`SR_IMM_WIDTH-1:0]};
    end

endmodule

// File: hw/controller.sv
module controller (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           s,
    input  simpleRiscPkg::decodedInstr_t   instr,
    output simpleRiscPkg::controlWord_t    ctrl,
    output logic                           w
);
    import simpleRiscPkg::*;

    ctrlState_t state;
    ctrlState_t nextState;
    logic       isMovImm;
    logic       isMovReg;
    logic       isAlu;
    logic       isCmp;

    assign isMovImm = (instr.opcode == opcodeMov) && (instr.op == opMovImm);
    assign isMovReg = (instr.opcode == opcodeMov) && (instr.op == opMovReg);
    assign isAlu    = (instr.opcode == opcodeAlu);
    assign isCmp    = isAlu && (instr.op == opCmp);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stWait;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = stWait;
        case (state)
            stWait: begin
                if (s && isMovImm) begin
                    nextState = stWriteRn;
                end else if (s && (isMovReg || isAlu)) begin
                    nextState = stReadRm;
                end                           // unknown encodings stay put
            end
            stWriteRn: nextState = stWait;
            stReadRm: begin
                if (isAlu && instr.op != opMvn) begin
                    nextState = stReadRn;
                end else begin
                    nextState = stShift;      // MOV reg and MVN skip A
                end
            end
            stReadRn:  nextState = stExecute;
            stShift:   nextState = stWriteRd;
            stExecute: nextState = isCmp ? stWait : stWriteRd;
            stWriteRd: nextState = stWait;
            default:   nextState = stWait;
        endcase
    end

    // strobes live for exactly one state
    always_comb begin
        ctrl = '0;
        case (state)
            stWriteRn: begin
                ctrl.nsel  = nselRn;
                ctrl.vsel  = vselImm;
                ctrl.write = 1'b1;
            end
            stReadRm: begin
                ctrl.nsel  = nselRm;
                ctrl.loadb = 1'b1;
            end
            stReadRn: begin
                ctrl.nsel  = nselRn;
                ctrl.loada = 1'b1;
            end
            stShift: begin
                ctrl.asel  = 1'b1;            // 0 + shifted B, or NOT B for MVN
                ctrl.loadc = 1'b1;
            end
            stExecute: begin
                ctrl.loadc = !isCmp;
                ctrl.loads = isCmp;           // CMP only touches flags
            end
            stWriteRd: begin
                ctrl.nsel  = nselRd;
                ctrl.vsel  = vselC;
                ctrl.write = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    assign w = (state == stWait);

endmodule

// File: hw/registerFile.sv
`include "simpleRisc_cfg.svh"

module registerFile (
    input  logic                            clk,
    input  logic                            writeEnable,
    input  logic [`SR_REG_SEL_WIDTH-1:0]    writeNum,
    input  logic [`SR_REG_SEL_WIDTH-1:0]    readNum,
    input  logic [`SR_WORD_WIDTH-1:0]       writeData,
    output logic [`SR_WORD_WIDTH-1:0]       readData
);

    logic [`SR_WORD_WIDTH-1:0] regs [`SR_REG_COUNT];

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            regs[writeNum] <= writeData;
        end
    end

    assign readData = regs[readNum];          // async read

endmodule

// File: hw/executeUnit.sv
`include "simpleRisc_cfg.svh"

module executeUnit (
    input  logic [`SR_WORD_WIDTH-1:0]      a,
    input  logic [`SR_WORD_WIDTH-1:0]      b,
    input  logic [`SR_WORD_WIDTH-1:0]      imm,
    input  simpleRiscPkg::shiftOp_t        shift,
    input  simpleRiscPkg::aluOp_t          aluOp,
    input  logic                           asel,
    input  logic                           bsel,
    output logic [`SR_WORD_WIDTH-1:0]      result,
    output simpleRiscPkg::statusFlags_t    flags
);
    import simpleRiscPkg::*;

    localparam int Msb = `SR_WORD_WIDTH - 1;

    logic [`SR_WORD_WIDTH-1:0] shifted;
    logic [`SR_WORD_WIDTH-1:0] ain;
    logic [`SR_WORD_WIDTH-1:0] bin;

    always_comb begin
        case (shift)
            shiftLeft:       shifted = {b[Msb-1:0], 1'b0};
            shiftRightLogic: shifted = {1'b0, b[Msb:1]};
            shiftRightArith: shifted = {b[Msb], b[Msb:1]};
            default:         shifted = b;
        endcase
    end

    assign ain = asel ? '0 : a;
    assign bin = bsel ? imm : shifted;

    always_comb begin
        case (aluOp)
            aluAdd:  result = ain + bin;
            aluSub:  result = ain - bin;
            aluAnd:  result = ain & bin;
            default: result = ~bin;
        endcase
    end

    always_comb begin
        flags.z = (result == '0);
        flags.n = result[Msb];
        case (aluOp)
            aluAdd:  flags.v = (ain[Msb] == bin[Msb]) && (result[Msb] != ain[Msb]);
            aluSub:  flags.v = (ain[Msb] != bin[Msb]) && (result[Msb] != ain[Msb]);
            default: flags.v = 1'b0;
        endcase
    end

endmodule

// File: hw/datapath.sv
`include "simpleRisc_cfg.svh"

module datapath (
    input  logic                           clk,
    input  logic                           reset,
    input  simpleRiscPkg::decodedInstr_t   instr,
    input  simpleRiscPkg::controlWord_t    ctrl,
    output logic [`SR_WORD_WIDTH-1:0]      out,
    output simpleRiscPkg::statusFlags_t    flags
);
    import simpleRiscPkg::*;

    logic [`SR_REG_SEL_WIDTH-1:0] regNum;
    logic [`SR_WORD_WIDTH-1:0]    writeData;
    logic [`SR_WORD_WIDTH-1:0]    readData;
    logic [`SR_WORD_WIDTH-1:0]    regA;
    logic [`SR_WORD_WIDTH-1:0]    regB;
    logic [`SR_WORD_WIDTH-1:0]    regC;
    logic [`SR_WORD_WIDTH-1:0]    aluResult;
    logic                         immWrite;
    statusFlags_t                 aluFlags;
    statusFlags_t                 status;

    // one-hot nsel to a binary register number
    always_comb begin
        case (ctrl.nsel)
            nselRd:  regNum = instr.rd;
            nselRm:  regNum = instr.rm;
            default: regNum = instr.rn;
        endcase
    end

    assign immWrite  = ctrl.write && (ctrl.vsel == vselImm);
    assign writeData = immWrite ? instr.imm : regC;

    registerFile regFile_i (
        .clk         (clk),
        .writeEnable (ctrl.write),
        .writeNum    (regNum),
        .readNum     (regNum),
        .writeData   (writeData),
        .readData    (readData)
    );

    always_ff @(posedge clk) begin
        if (ctrl.loada) begin
            regA <= readData;
        end
        if (ctrl.loadb) begin
            regB <= readData;
        end
    end

    executeUnit exec_i (
        .a      (regA),
        .b      (regB),
        .imm    (instr.imm),
        .shift  (instr.shift),
        .aluOp  (instr.aluOp),
        .asel   (ctrl.asel),
        .bsel   (ctrl.bsel),
        .result (aluResult),
        .flags  (aluFlags)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            regC   <= '0;
            status <= '0;
        end else begin
            if (ctrl.loadc) begin
                regC <= aluResult;
            end else if (immWrite) begin
                regC <= instr.imm;            // mov imm shows up on out too
            end
            if (ctrl.loads) begin
                status <= aluFlags;
            end
        end
    end

    assign out   = regC;
    assign flags = status;

endmodule

// File: hw/cpu.sv
`include "simpleRisc_cfg.svh"

module cpu (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        s,
    input  logic                        load,
    input  logic [`SR_WORD_WIDTH-1:0]   in,
    output logic [`SR_WORD_WIDTH-1:0]   out,
    output logic                        N,
    output logic                        V,
    output logic                        Z,
    output logic                        w
);
    import simpleRiscPkg::*;

    decodedInstr_t instr;
    controlWord_t  ctrl;
    statusFlags_t  flags;

    instructionDecoder decoder_i (
        .clk   (clk),
        .reset (reset),
        .load  (load),
        .in    (in),
        .instr (instr)
    );

    controller controller_i (
        .clk   (clk),
        .reset (reset),
        .s     (s),
        .instr (instr),
        .ctrl  (ctrl),
        .w     (w)
    );

    datapath datapath_i (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .ctrl  (ctrl),
        .out   (out),
        .flags (flags)
    );

    assign N = flags.n;
    assign V = flags.v;
    assign Z = flags.z;

endmodule

// File: testbench/cpu_properties.sv
module cpu_properties (
    input logic                           clk,
    input logic                           reset,
    input simpleRiscPkg::ctrlState_t      state,
    input simpleRiscPkg::controlWord_t    ctrl,
    input logic                           w
);
    timeunit 1ns;
    timeprecision 1ps;

    import simpleRiscPkg::*;

    // every busy state issues at least one strobe
    waitFlagMatchesState: assert property (
        @(posedge clk) disable iff (reset)
        w == !(ctrl.write || ctrl.loada || ctrl.loadb || ctrl.loadc || ctrl.loads)
    ) else $error("w is not high exactly while the controller is idle");

    // write, loads and loadc never overlap
    singleCommitStrobe: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0({ctrl.write, ctrl.loads, ctrl.loadc})
    ) else $error("more than one of write, loads, loadc active");

    idleStrobesClear: assert property (
        @(posedge clk)
        (state == stWait) |-> (ctrl == '0)
    ) else $error("control strobe active in the wait state");

endmodule

bind controller cpu_properties props_i (
    .clk   (clk),
    .reset (reset),
    .state (state),
    .ctrl  (ctrl),
    .w     (w)
);

// File: testbench/cpuTb.sv
`include "simpleRisc_cfg.svh"

module cpuTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int W = `SR_WORD_WIDTH;
    localparam int MaxSigned = (1 << (W - 1)) - 1;
    localparam int ClkPeriod = 20;
    localparam int NumInstr = 50;
    localparam int WatchdogCycles = NumInstr * 10 + 20;   // margin covers reset and idle
    localparam int MaxInstrCycles = 20;

    logic         clk;
    logic         reset;
    logic         s;
    logic         load;
    logic [W-1:0] in;
    logic [W-1:0] out;
    logic         N;
    logic         V;
    logic         Z;
    logic         w;

    logic [W-1:0] modelRegs [`SR_REG_COUNT];
    logic [W-1:0] modelC;
    logic [2:0]   modelFlags;                  // z n v
    logic [W-1:0] lastInstr;
    int           edgesTaken;
    int           errors;
    int           checks;
    event         resultReady;

    logic [1:0] aluOps [3] = '{2'b00, 2'b10, 2'b11};   // ADD, AND, MVN

    cpu cpu_i (
        .clk   (clk),
        .reset (reset),
        .s     (s),
        .load  (load),
        .in    (in),
        .out   (out),
        .N     (N),
        .V     (V),
        .Z     (Z),
        .w     (w)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    function automatic logic [W-1:0] shiftValue(input logic [W-1:0] v, input logic [1:0] sh);
        case (sh)
            2'b01:   return v << 1;
            2'b10:   return v >> 1;
            2'b11:   return $signed(v) >>> 1;
            default: return v;
        endcase
    endfunction

    // reference model, updates registers, C and flags for one instruction
    function automatic void predict(input logic [W-1:0] ins);
        logic [2:0]   opc;
        logic [1:0]   op;
        logic [2:0]   rn;
        logic [2:0]   rd;
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic [W-1:0] diff;
        int           diffInt;
        opc = ins[15:13];
        op  = ins[12:11];
        rn  = ins[10:8];
        rd  = ins[7:5];
        a   = modelRegs[rn];
        b   = shiftValue(modelRegs[ins[2:0]], ins[4:3]);
        if (opc == 3'b110 && op == 2'b01) begin
            modelC = {{(W - 8){ins[7]}}, ins[7:0]};
            modelRegs[rn] = modelC;
        end else if (opc == 3'b110 && op == 2'b00) begin
            modelC = b;
            modelRegs[rd] = modelC;
        end else if (opc == 3'b101) begin
            case (op)
                2'b00: modelC = a + b;
                2'b01: begin
                    diff = a - b;                  // CMP leaves C alone
                    diffInt = int'($signed(a)) - int'($signed(b));
                    modelFlags = {diff == '0, diff[W-1],
                                  (diffInt > MaxSigned) || (diffInt < -MaxSigned - 1)};
                end
                2'b10: modelC = a & b;
                default: modelC = ~b;
            endcase
            if (op != 2'b01) begin
                modelRegs[rd] = modelC;
            end
        end
    endfunction

    // edges from the s edge up to and including the return to wait
    function automatic int expectedEdges(input logic [W-1:0] ins);
        if (ins[15:13] == 3'b110) begin
            return (ins[12:11] == 2'b01) ? 2 : 4;
        end
        case (ins[12:11])
            2'b00, 2'b10: return 5;
            default:      return 4;
        endcase
    endfunction

    function automatic logic [W-1:0] encodeMovImm(input logic [2:0] rn, input logic [7:0] imm);
        return {3'b110, 2'b01, rn, imm};
    endfunction

    function automatic logic [W-1:0] encodeMovReg(input logic [2:0] rd, input logic [2:0] rm,
                                                   input logic [1:0] sh);
        return {3'b110, 2'b00, 3'b000, rd, sh, rm};
    endfunction

    function automatic logic [W-1:0] encodeAlu(input logic [1:0] op, input logic [2:0] rn,
                                                input logic [2:0] rd, input logic [2:0] rm,
                                                input logic [1:0] sh);
        return {3'b101, op, rn, rd, sh, rm};
    endfunction

    function automatic logic [2:0] randomReg();
        return 3'($urandom_range(0, 7));
    endfunction

    // entered and left 2 ns after a rising edge
    task automatic runInstruction(input logic [W-1:0] ins, input bit noisy);
        int cycles;
        in = ins;
        load = 1'b1;
        @(posedge clk);
        #2;
        load = 1'b0;
        s = 1'b1;
        @(posedge clk);
        #2;
        s = 1'b0;
        predict(ins);
        cycles = 0;
        while (w !== 1'b1 && cycles < MaxInstrCycles) begin
            if (noisy) begin
                s = 1'($urandom_range(0, 1));      // ignored, w is low
                in = W'($urandom());
            end
            @(posedge clk);
            #2;
            cycles++;
        end
        s = 1'b0;
        if (cycles >= MaxInstrCycles) begin
            errors++;
            $display("instruction %h never returned to the wait state", ins);
        end else begin
            lastInstr = ins;
            edgesTaken = cycles + 1;
            -> resultReady;
        end
    endtask

    always @(resultReady) begin
        checks++;
        if (out !== modelC) begin
            errors++;
            $display("[FAIL] out: got %h expected %h, instruction %h", out, modelC, lastInstr);
        end
        if ({Z, N, V} !== modelFlags) begin
            errors++;
            $display("[FAIL] {Z,N,V}: got %h expected %h, instruction %h",
                     {Z, N, V}, modelFlags, lastInstr);
        end
        if (edgesTaken != expectedEdges(lastInstr)) begin
            errors++;
            $display("instruction %h finished after %0d edges instead of %0d",
                     lastInstr, edgesTaken, expectedEdges(lastInstr));
        end
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("watchdog expired before the tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int         i;
        logic [7:0] imm;
        void'($urandom(32'h530ddcad));
        clk = 1'b0;
        reset = 1'b1;
        s = 1'b0;
        load = 1'b0;
        in = '0;
        errors = 0;
        checks = 0;
        modelC = '0;
        modelFlags = '0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        if (w !== 1'b1) begin
            errors++;
            $display("[FAIL] w: got %h expected 1", w);
        end
        if ({N, V, Z} !== 3'b000) begin
            errors++;
            $display("[FAIL] {N,V,Z}: got %h expected 0", {N, V, Z});
        end
        if (out !== '0) begin
            errors++;
            $display("[FAIL] out: got %h expected 0", out);
        end

        for (i = 0; i < `SR_REG_COUNT; i++) begin
            imm = 8'($urandom());
            imm[7] = i[0];                         // odd registers negative
            runInstruction(encodeMovImm(3'(i), imm), 1'b0);
        end
        for (i = 0; i < 8; i++) begin
            runInstruction(encodeMovReg(randomReg(), randomReg(), 2'(i % 4)), 1'b0);
        end
        for (i = 0; i < 12; i++) begin
            runInstruction(encodeAlu(aluOps[2'($urandom_range(0, 2))], randomReg(),
                                     randomReg(), randomReg(), 2'($urandom_range(0, 3))), 1'b0);
        end
        runInstruction(encodeAlu(2'b00, 3'd3, 3'd3, 3'd3, 2'b00), 1'b0);
        runInstruction(encodeAlu(2'b10, 3'd5, 3'd5, 3'd2, 2'b01), 1'b0);

        runInstruction(encodeMovImm(3'd1, 8'hff), 1'b0);                 // r1 = ffff
        runInstruction(encodeMovReg(3'd2, 3'd1, 2'b10), 1'b0);           // r2 = 7fff
        runInstruction(encodeAlu(2'b11, 3'd0, 3'd3, 3'd2, 2'b00), 1'b0); // r3 = 8000
        runInstruction(encodeMovImm(3'd4, 8'd5), 1'b0);
        runInstruction(encodeMovImm(3'd5, 8'd9), 1'b0);
        runInstruction(encodeAlu(2'b01, 3'd2, 3'd0, 3'd2, 2'b00), 1'b0); // equal
        runInstruction(encodeAlu(2'b01, 3'd4, 3'd0, 3'd5, 2'b00), 1'b0); // smaller
        runInstruction(encodeAlu(2'b01, 3'd2, 3'd0, 3'd3, 2'b00), 1'b0); // overflow
        runInstruction(encodeAlu(2'b01, 3'd3, 3'd0, 3'd4, 2'b00), 1'b0);

        for (i = 0; i < 10; i++) begin
            runInstruction(encodeAlu(2'($urandom_range(0, 3)), randomReg(), randomReg(),
                                     randomReg(), 2'($urandom_range(0, 3))), i < 6);
        end

        @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
hw/simpleRiscPkg.sv
hw/instructionDecoder.sv
hw/controller.sv
hw/registerFile.sv
hw/executeUnit.sv
hw/datapath.sv
hw/cpu.sv
testbench/cpu_properties.sv
testbench/cpuTb.sv

// File: Makefile
TOP = cpuTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
